// File: alu_settings.svh
// execute stage widths and divider iteration count.
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// datapath word width.
`define ALU_WIDTH 32

// shift amount taken from the low bits of opA.
`define SHAMT_WIDTH 5

// one restoring step per quotient bit.
`define DIV_STEPS `ALU_WIDTH

`endif

// File: aluPkg.sv
// shared enum types for instruction class, ALU operation and control state.
`default_nettype none

package aluPkg;

    typedef enum logic [2:0]
    {
        TYPE_R   = 3'b000,
        TYPE_I   = 3'b001,
        TYPE_MEM = 3'b010 // address sum only.
    } instType_t;

    typedef enum logic [3:0]
    {
        OP_ADD  = 4'b0000,
        OP_SUB  = 4'b0001,
        OP_SLT  = 4'b0010,
        OP_DIV  = 4'b0011,
        OP_MUL  = 4'b0100,
        OP_AND  = 4'b0101,
        OP_OR   = 4'b0110,
        OP_NOR  = 4'b0111,
        OP_XOR  = 4'b1000,
        OP_SLL  = 4'b1001,
        OP_SRA  = 4'b1010,
        OP_SRL  = 4'b1011,
        OP_LUI  = 4'b1100,
        OP_NONE = 4'b1111 // unknown class or field.
    } aluOp_t;

    typedef enum logic [1:0]
    {
        S_IDLE    = 2'b00,
        S_ISSUE   = 2'b01,
        S_MULWAIT = 2'b10,
        S_DIVWAIT = 2'b11
    } execState_t;

endpackage

`default_nettype wire

// File: aluDecoder.sv
// maps instruction class and function/opcode field to an ALU operation and mode.
`default_nettype none
`timescale 1ns/100ps

module aluDecoder import aluPkg::*;
(
    input  instType_t  instType,
    input  logic [5:0] func,
    output aluOp_t     aluOp,
    output logic       unsignedMode,
    output logic       illegal
);

    always_comb
    begin
        aluOp        = OP_NONE;
        unsignedMode = 1'b0;
        case (instType)
            TYPE_R:
            begin
                case (func)
                    6'b100000: aluOp = OP_ADD;
                    6'b100001: {aluOp, unsignedMode} = {OP_ADD, 1'b1}; // addu.
                    6'b100010: aluOp = OP_SUB;
                    6'b100011: {aluOp, unsignedMode} = {OP_SUB, 1'b1}; // subu.
                    6'b101010: aluOp = OP_SLT;
                    6'b101011: {aluOp, unsignedMode} = {OP_SLT, 1'b1}; // sltu.
                    6'b011010: aluOp = OP_DIV;
                    6'b011011: {aluOp, unsignedMode} = {OP_DIV, 1'b1}; // divu.
                    6'b011000: aluOp = OP_MUL;
                    6'b011001: {aluOp, unsignedMode} = {OP_MUL, 1'b1}; // multu.
                    6'b100100: aluOp = OP_AND;
                    6'b100101: aluOp = OP_OR;
                    6'b100111: aluOp = OP_NOR;
                    6'b100110: aluOp = OP_XOR;
                    6'b000100: aluOp = OP_SLL; // sllv.
                    6'b000111: aluOp = OP_SRA; // srav.
                    6'b000110: aluOp = OP_SRL; // srlv.
                    default:   aluOp = OP_NONE;
                endcase
            end
            TYPE_I:
            begin
                // func carries the opcode field here.
                case (func)
                    6'b001000: aluOp = OP_ADD;
                    6'b001001: {aluOp, unsignedMode} = {OP_ADD, 1'b1}; // addiu.
                    6'b001010: aluOp = OP_SLT;
                    6'b001011: {aluOp, unsignedMode} = {OP_SLT, 1'b1}; // sltiu.
                    6'b001100: aluOp = OP_AND;
                    6'b001101: aluOp = OP_OR;
                    6'b001110: aluOp = OP_XOR;
                    6'b001111: aluOp = OP_LUI;
                    default:   aluOp = OP_NONE;
                endcase
            end
            TYPE_MEM: aluOp = OP_ADD; // base plus offset.
            default:  aluOp = OP_NONE;
        endcase
    end

    assign illegal = (aluOp == OP_NONE);

    // a known class and field must never leave the operation undefined.
    always_comb
    begin
        if (!$isunknown({instType, func}))
        begin
            assert (!$isunknown(aluOp))
            else $error("aluDecoder: aluOp unknown for known inputs");
        end
    end

endmodule

`default_nettype wire

// File: execControl.sv
// control FSM that latches the decoded operation and sequences issue, wait and done.
`default_nettype none
`timescale 1ns/100ps

module execControl import aluPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  aluOp_t aluOp,
    input  logic   unsignedMode,
    input  logic   illegal,
    input  logic   divDone,
    output aluOp_t opReg,
    output logic   unsignedReg,
    output logic   illegalReg,
    output logic   capture,
    output logic   divStart,
    output logic   resultLoad,
    output logic   busy,
    output logic   done
);

    execState_t state;
    logic       loadReg; // delayed load for ALU and MUL paths.

    assign capture = start && !busy && (state == S_IDLE);

    // the divider path loads in the cycle its done pulse arrives.
    assign resultLoad = loadReg || ((state == S_DIVWAIT) && divDone);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= S_IDLE;
            opReg       <= OP_NONE;
            unsignedReg <= 1'b0;
            illegalReg  <= 1'b0;
            divStart    <= 1'b0;
            loadReg     <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            divStart <= 1'b0;
            loadReg  <= 1'b0;
            done     <= resultLoad; // done trails the load by one cycle.
            if (resultLoad)
                busy <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (capture)
                    begin
                        opReg       <= aluOp;
                        unsignedReg <= unsignedMode;
                        illegalReg  <= illegal;
                        busy        <= 1'b1;
                        if (illegal)
                            state <= S_ISSUE;
                        else if (aluOp == OP_MUL)
                            state <= S_MULWAIT;
                        else if (aluOp == OP_DIV)
                        begin
                            state    <= S_DIVWAIT;
                            divStart <= 1'b1;
                        end
                        else
                            state <= S_ISSUE;
                    end
                end
                S_MULWAIT: state <= S_ISSUE; // product registers this cycle.
                S_ISSUE:
                begin
                    loadReg <= 1'b1;
                    state   <= S_IDLE;
                end
                S_DIVWAIT:
                begin
                    if (divDone)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_loadNotWithDone: assert property (@(posedge clk) disable iff (rst)
        !(done && resultLoad));

    // the divider only finishes while the FSM is waiting for it.
    a_divDoneInWait: assert property (@(posedge clk) disable iff (rst)
        divDone |-> (state == S_DIVWAIT));

endmodule

`default_nettype wire

// File: aluCore.sv
// single-cycle arithmetic, logic, compare and shift datapath with result registers.
`default_nettype none
`timescale 1ns/100ps
`include "alu_settings.svh"

module aluCore import aluPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ALU_WIDTH-1:0]     opA,
    input  logic [`ALU_WIDTH-1:0]     opB,
    input  logic                      capture,
    input  aluOp_t                    opReg,
    input  logic                      unsignedReg,
    input  logic                      illegalReg,
    input  logic                      resultLoad,
    input  logic [2*`ALU_WIDTH-1:0]   product,
    input  logic [`ALU_WIDTH-1:0]     quotient,
    input  logic [`ALU_WIDTH-1:0]     remainder,
    output logic [`ALU_WIDTH-1:0]     opAReg,
    output logic [`ALU_WIDTH-1:0]     opBReg,
    output logic [`ALU_WIDTH-1:0]     result,
    output logic [`ALU_WIDTH-1:0]     resultHi
);

    localparam int HALF = `ALU_WIDTH / 2;

    logic [`SHAMT_WIDTH-1:0] shamt;
    logic                    lessThan;
    logic [`ALU_WIDTH-1:0]   aluResult;

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            opAReg <= opA;
            opBReg <= opB;
        end
    end

    assign shamt    = opAReg[`SHAMT_WIDTH-1:0];
    assign lessThan = unsignedReg ? (opAReg < opBReg)
                                  : ($signed(opAReg) < $signed(opBReg));

    always_comb
    begin
        case (opReg)
            OP_ADD:  aluResult = opAReg + opBReg; // wraps.
            OP_SUB:  aluResult = opAReg - opBReg;
            OP_SLT:  aluResult = {{(`ALU_WIDTH-1){1'b0}}, lessThan};
            OP_AND:  aluResult = opAReg & opBReg;
            OP_OR:   aluResult = opAReg | opBReg;
            OP_NOR:  aluResult = ~(opAReg | opBReg);
            OP_XOR:  aluResult = opAReg ^ opBReg;
            OP_SLL:  aluResult = opBReg << shamt;
            OP_SRL:  aluResult = opBReg >> shamt;
            OP_SRA:  aluResult = $signed(opBReg) >>> shamt;
            OP_LUI:  aluResult = {opBReg[HALF-1:0], {HALF{1'b0}}};
            default: aluResult = '0; // MUL, DIV, NONE.
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            result   <= '0;
            resultHi <= '0;
        end
        else if (resultLoad)
        begin
            if (illegalReg)
            begin
                result   <= '0;
                resultHi <= '0;
            end
            else
            begin
                case (opReg)
                    OP_MUL:
                    begin
                        result   <= product[`ALU_WIDTH-1:0];
                        resultHi <= product[2*`ALU_WIDTH-1:`ALU_WIDTH];
                    end
                    OP_DIV:
                    begin
                        result   <= quotient;
                        resultHi <= remainder;
                    end
                    default:
                    begin
                        result   <= aluResult;
                        resultHi <= '0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: mulUnit.sv
// registered signed or unsigned multiplier producing a double-width product.
`default_nettype none
`timescale 1ns/100ps
`include "alu_settings.svh"

module mulUnit
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`ALU_WIDTH-1:0]   opAReg,
    input  logic [`ALU_WIDTH-1:0]   opBReg,
    input  logic                    unsignedReg,
    output logic [2*`ALU_WIDTH-1:0] product
);

    // recomputed every cycle, sampled by the core once the FSM has waited.
    always_ff @(posedge clk)
    begin
        if (rst)
            product <= '0;
        else if (unsignedReg)
            product <= {{`ALU_WIDTH{1'b0}}, opAReg} * {{`ALU_WIDTH{1'b0}}, opBReg};
        else
            product <= $signed({{`ALU_WIDTH{opAReg[`ALU_WIDTH-1]}}, opAReg})
                     * $signed({{`ALU_WIDTH{opBReg[`ALU_WIDTH-1]}}, opBReg});
    end

endmodule

`default_nettype wire

// File: divUnit.sv
// iterative restoring divider with sign correction and divide-by-zero result.
`default_nettype none
`timescale 1ns/100ps
`include "alu_settings.svh"

module divUnit
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  divStart,
    input  logic [`ALU_WIDTH-1:0] opAReg,
    input  logic [`ALU_WIDTH-1:0] opBReg,
    input  logic                  unsignedReg,
    output logic [`ALU_WIDTH-1:0] quotient,
    output logic [`ALU_WIDTH-1:0] remainder,
    output logic                  divDone
);

    localparam int W  = `ALU_WIDTH;
    localparam int CW = $clog2(`DIV_STEPS + 1);
    localparam logic [CW-1:0] LAST = CW'(`DIV_STEPS);

    logic          running;
    logic [CW-1:0] stepCount;
    logic          negA;
    logic          negB;
    logic [W-1:0]  aMag;
    logic [W-1:0]  bMag;
    logic [W-1:0]  remReg;
    logic [W-1:0]  quoReg;
    logic [W:0]    shifted;
    logic [W:0]    trial;

    // operands stay latched in the core for the whole division.
    assign negA    = !unsignedReg && opAReg[W-1];
    assign negB    = !unsignedReg && opBReg[W-1];
    assign aMag    = negA ? -opAReg : opAReg;
    assign bMag    = negB ? -opBReg : opBReg;
    assign shifted = {remReg, quoReg[W-1]};
    assign trial   = shifted - {1'b0, bMag};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running   <= 1'b0;
            stepCount <= '0;
            divDone   <= 1'b0;
        end
        else
        begin
            divDone <= 1'b0;
            if (divStart)
            begin
                running   <= 1'b1;
                stepCount <= '0;
            end
            else if (running)
            begin
                if (stepCount == LAST)
                begin
                    running <= 1'b0; // sign fix cycle.
                    divDone <= 1'b1;
                end
                else
                    stepCount <= stepCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (divStart)
        begin
            remReg <= '0;
            quoReg <= aMag;
        end
        else if (running && (stepCount != LAST))
        begin
            if (!trial[W])
            begin
                remReg <= trial[W-1:0];
                quoReg <= {quoReg[W-2:0], 1'b1};
            end
            else
            begin
                remReg <= shifted[W-1:0]; // restore.
                quoReg <= {quoReg[W-2:0], 1'b0};
            end
        end
        else if (running)
        begin
            if (bMag == '0)
            begin
                quotient  <= '1;
                remainder <= opAReg;
            end
            else
            begin
                quotient  <= (negA ^ negB) ? -quoReg : quoReg; // truncate toward zero.
                remainder <= negA ? -remReg : remReg;
            end
        end
    end

    a_stepBound: assert property (@(posedge clk) disable iff (rst)
        stepCount <= LAST);

endmodule

`default_nettype wire

// File: aluExecUnit.sv
// execute stage top connecting decoder, control FSM, ALU, multiplier and divider.
`default_nettype none
`timescale 1ns/100ps
`include "alu_settings.svh"

module aluExecUnit import aluPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  instType_t             instType,
    input  logic [5:0]            func,
    input  logic [`ALU_WIDTH-1:0] opA,
    input  logic [`ALU_WIDTH-1:0] opB,
    output logic [`ALU_WIDTH-1:0] result,
    output logic [`ALU_WIDTH-1:0] resultHi,
    output logic                  illegal,
    output logic                  busy,
    output logic                  done
);

    aluOp_t                    aluOp;
    aluOp_t                    opReg;
    logic                      unsignedMode;
    logic                      unsignedReg;
    logic                      decIllegal;
    logic                      capture;
    logic                      divStart;
    logic                      divDone;
    logic                      resultLoad;
    logic [`ALU_WIDTH-1:0]     opAReg;
    logic [`ALU_WIDTH-1:0]     opBReg;
    logic [2*`ALU_WIDTH-1:0]   product;
    logic [`ALU_WIDTH-1:0]     quotient;
    logic [`ALU_WIDTH-1:0]     remainder;

    aluDecoder i_aluDecoder
    (
        .instType     (instType),
        .func         (func),
        .aluOp        (aluOp),
        .unsignedMode (unsignedMode),
        .illegal      (decIllegal)
    );

    execControl i_execControl
    (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .aluOp        (aluOp),
        .unsignedMode (unsignedMode),
        .illegal      (decIllegal),
        .divDone      (divDone),
        .opReg        (opReg),
        .unsignedReg  (unsignedReg),
        .illegalReg   (illegal), // latched flag goes straight out.
        .capture      (capture),
        .divStart     (divStart),
        .resultLoad   (resultLoad),
        .busy         (busy),
        .done         (done)
    );

    aluCore i_aluCore
    (
        .clk          (clk),
        .rst          (rst),
        .opA          (opA),
        .opB          (opB),
        .capture      (capture),
        .opReg        (opReg),
        .unsignedReg  (unsignedReg),
        .illegalReg   (illegal),
        .resultLoad   (resultLoad),
        .product      (product),
        .quotient     (quotient),
        .remainder    (remainder),
        .opAReg       (opAReg),
        .opBReg       (opBReg),
        .result       (result),
        .resultHi     (resultHi)
    );

    mulUnit i_mulUnit
    (
        .clk          (clk),
        .rst          (rst),
        .opAReg       (opAReg),
        .opBReg       (opBReg),
        .unsignedReg  (unsignedReg),
        .product      (product)
    );

    divUnit i_divUnit
    (
        .clk          (clk),
        .rst          (rst),
        .divStart     (divStart),
        .opAReg       (opAReg),
        .opBReg       (opBReg),
        .unsignedReg  (unsignedReg),
        .quotient     (quotient),
        .remainder    (remainder),
        .divDone      (divDone)
    );

endmodule

`default_nettype wire

// File: aluChecker.sv
// testbench checker comparing execute stage outputs against expected values on each done pulse.
`default_nettype none
`timescale 1ns/100ps
`include "alu_settings.svh"

module aluChecker
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  busy,
    input  logic                  done,
    input  logic [`ALU_WIDTH-1:0] result,
    input  logic [`ALU_WIDTH-1:0] resultHi,
    input  logic                  illegal,
    output int                    mismatchCount,
    output int                    checkCount
);

    logic [8*16-1:0]       expName;
    logic [`ALU_WIDTH-1:0] expResult;
    logic [`ALU_WIDTH-1:0] expHi;
    logic                  expIllegal;
    logic                  inFlight = 1'b0; // accepted start not yet answered by done.
    int                    loadCount = 0; // vectors handed over so far.
    int                    errCount = 0;
    int                    doneCount = 0;

    assign mismatchCount = errCount;
    assign checkCount    = doneCount;

    // called by the testbench before each start.
    task automatic loadExpected
    (
        input logic [8*16-1:0]       name,
        input logic [`ALU_WIDTH-1:0] res,
        input logic [`ALU_WIDTH-1:0] hi,
        input logic                  ill
    );
        expName    = name;
        expResult  = res;
        expHi      = hi;
        expIllegal = ill;
        loadCount++;
    endtask

    task automatic compareWord
    (
        input string                 field,
        input logic [`ALU_WIDTH-1:0] expected,
        input logic [`ALU_WIDTH-1:0] actual
    );
        if (actual !== expected)
        begin
            $display("CHECK FAILED %0s %0s: expected %h, actual %h",
                     expName, field, expected, actual);
            errCount++;
        end
    endtask

    // outputs are valid in the cycle where done is high.
    always @(posedge clk)
    begin
        // busy rises on the edge after start and holds until done.
        if (!rst && inFlight && !done && !busy)
        begin
            $display("busy was low at %0t while test %0s was still running", $time, expName);
            errCount++;
        end
        if (!rst && done)
        begin
            if (doneCount >= loadCount)
            begin
                $display("unexpected done pulse at %0t with no vector in flight", $time);
                errCount++;
            end
            else
            begin
                compareWord("result", expResult, result);
                compareWord("resultHi", expHi, resultHi);
                compareWord("illegal", {{(`ALU_WIDTH-1){1'b0}}, expIllegal},
                            {{(`ALU_WIDTH-1){1'b0}}, illegal});
                doneCount = loadCount; // a timed out vector is skipped.
            end
        end
        if (rst || done)
            inFlight = 1'b0;
        else if (start && !busy)
            inFlight = 1'b1;
    end

endmodule

`default_nettype wire

// File: tbAluExec.sv
// testbench top driving the execute stage from the stimulus file and reporting the outcome.
`default_nettype none
`timescale 1ns/100ps
`include "alu_settings.svh"

module tbAluExec import aluPkg::*;
();

    localparam int DONE_TIMEOUT = `DIV_STEPS + 20; // cycles allowed per operation.

    logic                  clk;
    logic                  rst;
    logic                  start;
    instType_t             instType;
    logic [5:0]            func;
    logic [`ALU_WIDTH-1:0] opA;
    logic [`ALU_WIDTH-1:0] opB;
    logic [`ALU_WIDTH-1:0] result;
    logic [`ALU_WIDTH-1:0] resultHi;
    logic                  illegal;
    logic                  busy;
    logic                  done;
    int                    mismatchCount;
    int                    checkCount;
    int                    timeoutCount;
    int                    fileErrors;
    int                    vectorCount;
    int                    fd;
    int                    fieldCount;
    logic [8*128-1:0]      lineText;
    logic [8*16-1:0]       name;
    logic [31:0]           cls;
    logic [31:0]           fld;
    logic [31:0]           a;
    logic [31:0]           b;
    logic [31:0]           expRes;
    logic [31:0]           expHi;
    logic [31:0]           expIll;

    aluExecUnit i_aluExecUnit
    (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .instType (instType),
        .func     (func),
        .opA      (opA),
        .opB      (opB),
        .result   (result),
        .resultHi (resultHi),
        .illegal  (illegal),
        .busy     (busy),
        .done     (done)
    );

    aluChecker i_aluChecker
    (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .result        (result),
        .resultHi      (resultHi),
        .illegal       (illegal),
        .mismatchCount (mismatchCount),
        .checkCount    (checkCount)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one start pulse, then wait for done.
    task automatic runVector
    (
        input logic [8*16-1:0]       vecName,
        input logic [2:0]            vecClass,
        input logic [5:0]            vecField,
        input logic [`ALU_WIDTH-1:0] vecA,
        input logic [`ALU_WIDTH-1:0] vecB,
        input logic [`ALU_WIDTH-1:0] vecRes,
        input logic [`ALU_WIDTH-1:0] vecHi,
        input logic                  vecIll
    );
        int waitCycles;
        @(posedge clk);
        i_aluChecker.loadExpected(vecName, vecRes, vecHi, vecIll);
        start    <= 1'b1;
        instType <= instType_t'(vecClass);
        func     <= vecField;
        opA      <= vecA;
        opB      <= vecB;
        @(posedge clk);
        start <= 1'b0;
        waitCycles = 0;
        while (!done && waitCycles < DONE_TIMEOUT)
        begin
            @(posedge clk);
            waitCycles++;
        end
        if (!done)
        begin
            $display("timeout: test %0s got no done within %0d cycles", vecName, DONE_TIMEOUT);
            timeoutCount++;
        end
    endtask

    initial
    begin
        rst          = 1'b1;
        start        = 1'b0;
        instType     = TYPE_R;
        func         = '0;
        opA          = '0;
        opB          = '0;
        timeoutCount = 0;
        fileErrors   = 0;
        vectorCount  = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("alu_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open alu_stimulus.txt for reading");
            fileErrors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                lineText = '0;
                void'($fgets(lineText, fd));
                fieldCount = $sscanf(lineText, "%s %h %h %h %h %h %h %h",
                                     name, cls, fld, a, b, expRes, expHi, expIll);
                if (fieldCount == 8) // comment and blank lines fall through.
                begin
                    runVector(name, cls[2:0], fld[5:0], a, b, expRes, expHi, expIll[0]);
                    vectorCount++;
                end
            end
            $fclose(fd);
        end
        if (vectorCount == 0)
        begin
            $display("no vectors were read from the stimulus file");
            fileErrors++;
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d timeouts, %0d file errors, %0d of %0d vectors checked",
                 mismatchCount, timeoutCount, fileErrors, checkCount, vectorCount);
        if (mismatchCount == 0 && timeoutCount == 0 && fileErrors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: alu_stimulus.txt
# name class func opA opB result resultHi illegal
# all fields but name in hex and class 0 is R, 1 is I and 2 is memory
add_basic 0 20 00000005 00000007 0000000c 00000000 0
add_wrap 0 20 ffffffff 00000002 00000001 00000000 0
addu_wrap 0 21 80000000 80000000 00000000 00000000 0
sub_wrap 0 22 00000000 00000001 ffffffff 00000000 0
subu_basic 0 23 00000010 00000003 0000000d 00000000 0
and_mask 0 24 f0f0ff00 0ff00ff0 00f00f00 00000000 0
or_mask 0 25 f0f0ff00 0ff00ff0 fff0fff0 00000000 0
nor_mask 0 27 f0f0ff00 0ff00ff0 000f000f 00000000 0
xor_mask 0 26 f0f0ff00 0ff00ff0 ff00f0f0 00000000 0
slt_signed 0 2a ffffffff 00000001 00000001 00000000 0
sltu_big 0 2b ffffffff 00000001 00000000 00000000 0
slti_neg 1 0a fffffff0 fffffff8 00000001 00000000 0
sltiu_big 1 0b fffffff0 00000010 00000000 00000000 0
addi_neg 1 08 00001000 fffffffc 00000ffc 00000000 0
lui_upper 1 0f 12345678 0000abcd abcd0000 00000000 0
sllv_31 0 04 0000001f 00000001 80000000 00000000 0
sllv_0 0 04 00000000 deadbeef deadbeef 00000000 0
srlv_31 0 06 0000003f 80000000 00000001 00000000 0
srav_neg 0 07 00000004 80000000 f8000000 00000000 0
srav_zero 0 07 00000020 80000001 80000001 00000000 0
srav_31 0 07 0000001f 80000000 ffffffff 00000000 0
mult_signed 0 18 fffffffe 00000003 fffffffa ffffffff 0
mult_big 0 18 7fffffff 7fffffff 00000001 3fffffff 0
multu_max 0 19 ffffffff ffffffff 00000001 fffffffe 0
div_neg 0 1a fffffff9 00000002 fffffffd ffffffff 0
div_neg_divisor 0 1a 00000007 fffffffe fffffffd 00000001 0
div_exact 0 1a ffffff9c 0000000a fffffff6 00000000 0
divu_big 0 1b ffffffff 00000010 0fffffff 0000000f 0
div_zero 0 1a fffffff9 00000000 ffffffff fffffff9 0
divu_zero 0 1b 12345678 00000000 ffffffff 12345678 0
illegal_class 5 20 00000001 00000002 00000000 00000000 1
illegal_rfunc 0 3f 00000001 00000002 00000000 00000000 1
illegal_ifunc 1 23 00000001 00000002 00000000 00000000 1
mem_addr 2 23 00001000 00000010 00001010 00000000 0

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tbAluExec
FLIST     := flist.f
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FLIST)) alu_settings.svh
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN) alu_stimulus.txt
	./$(BIN) > $(LOG) 2>&1; cat $(LOG); grep -q '^TEST PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+.
aluPkg.sv
aluDecoder.sv
execControl.sv
aluCore.sv
mulUnit.sv
divUnit.sv
aluExecUnit.sv
aluChecker.sv
tbAluExec.sv
